/* common/icache_pkg.sv */
// Instruction cache shared definitions
// Geometry defaults for the module parameters, the controller state
// and the APB register map

package icache_pkg;

   // Address width in bits
   localparam int ADDR_W = 32;

   // Byte offset width inside a line, 4 gives four 32-bit words
   localparam int BLOCK_W = 4;

   // Set index width, 64 sets
   localparam int SET_W = 6;

   // Associativity, two or more
   localparam int NUM_WAYS = 2;

   // Controller states
   typedef enum logic [1:0] {
      IC_IDLE   = 2'd0,
      IC_LOOKUP = 2'd1,
      IC_REFILL = 2'd2,
      IC_INVAL  = 2'd3
   } ic_state_e;

   // APB register word offsets
   typedef enum logic [2:0] {
      CFG_INVAL = 3'd0,
      CFG_LAST  = 3'd4
   } cfg_reg_e;

endpackage

/* common/icache_tag_if.sv */
// Tag RAM access between the cache controller and the tag store
// One synchronous read port and one write port, one entry per set

`timescale 1ns/1ns

interface icache_tag_if #(
   parameter int SET_W   = icache_pkg::SET_W,
   parameter int ENTRY_W = 1
) ();

   logic [SET_W-1:0]   rd_idx;
   logic [SET_W-1:0]   wr_idx;
   logic               we;
   logic [ENTRY_W-1:0] wr_entry;
   // Entry addressed by rd_idx in the previous cycle
   logic [ENTRY_W-1:0] rd_entry;

   modport ctrl (output rd_idx, output wr_idx, output we, output wr_entry,
                 input rd_entry);

   modport store (input rd_idx, input wr_idx, input we, input wr_entry,
                  output rd_entry);

endinterface

/* rtl/icache_cfg_apb.sv */
// Cache configuration registers on APB
// Write of CFG_INVAL queues a set invalidation and holds PREADY low
// until the controller takes it, CFG_LAST reads back the index

`timescale 1ns/1ns

module icache_cfg_apb #(
   parameter int SET_W = icache_pkg::SET_W
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             psel_i,
   input  logic             penable_i,
   input  logic             pwrite_i,
   input  logic [2:0]       paddr_i,
   input  logic [31:0]      pwdata_i,
   output logic [31:0]      prdata_o,
   output logic             pready_o,
   output logic             pslverr_o,
   output logic             inval_req_o,
   output logic [SET_W-1:0] inval_set_o,
   input  logic             inval_ack_i
);

   import icache_pkg::*;

   cfg_reg_e         reg_sel;
   logic             access;
   logic             wr_inval;
   logic             mapped;
   logic             pending;
   logic             done;
   logic [SET_W-1:0] last_set;

   assign reg_sel  = cfg_reg_e'(paddr_i);
   assign access   = psel_i && penable_i;
   assign wr_inval = access && pwrite_i && (reg_sel == CFG_INVAL);
   assign mapped   = (reg_sel == CFG_INVAL) || (reg_sel == CFG_LAST);

   // Invalidate write waits for the ack, everything else is zero wait
   assign pready_o  = wr_inval ? done : 1'b1;
   assign pslverr_o = access && !mapped;
   assign prdata_o  = (psel_i && !pwrite_i && reg_sel == CFG_LAST) ?
                      {{(32-SET_W){1'b0}}, last_set} : '0;

   assign inval_req_o = pending;
   assign inval_set_o = last_set;

   always_ff @(posedge clk) begin
      if (rst) begin
         pending <= 1'b0;
         done    <= 1'b0;
      end else if (pending) begin
         if (inval_ack_i) begin
            pending <= 1'b0;
            done    <= 1'b1;
         end
      end else if (wr_inval && !done) begin
         pending <= 1'b1;
      end else if (wr_inval) begin
         // Transfer completes this cycle
         done <= 1'b0;
      end
   end

   // Last index written, also the set being invalidated
   always_ff @(posedge clk) begin
      if (wr_inval && !pending && !done) begin
         last_set <= pwdata_i[SET_W-1:0];
      end
   end

endmodule

/* icache/icache_lru.sv */
// Pairwise LRU for N ways
// One history bit per pair of ways, bit set when the lower way was
// used after the higher one

`timescale 1ns/1ns

module icache_lru #(
   parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
   input  logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0] hist_i,
   input  logic [NUM_WAYS-1:0]                access_i,
   output logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0] hist_o,
   output logic [NUM_WAYS-1:0]                victim_o
);

   always_comb begin
      int idx;
      idx      = 0;
      hist_o   = hist_i;
      victim_o = '1;
      for (int i = 0; i < NUM_WAYS - 1; i++) begin
         for (int j = i + 1; j < NUM_WAYS; j++) begin
            // Newer way of each pair cannot be the victim
            if (hist_i[idx]) begin
               victim_o[i] = 1'b0;
            end else begin
               victim_o[j] = 1'b0;
            end
            // Accessed way becomes newer than its partner
            if (access_i[i]) begin
               hist_o[idx] = 1'b1;
            end else if (access_i[j]) begin
               hist_o[idx] = 1'b0;
            end
            idx = idx + 1;
         end
      end
   end

endmodule

/* icache/icache_data_ways.sv */
// Instruction cache data store
// One synchronous word RAM per way and the output way select

`timescale 1ns/1ns

module icache_data_ways #(
   parameter int BLOCK_W  = icache_pkg::BLOCK_W,
   parameter int SET_W    = icache_pkg::SET_W,
   parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
   input  logic                      clk,
   input  logic [SET_W+BLOCK_W-3:0]  radr_i,
   input  logic [SET_W+BLOCK_W-3:0]  wadr_i,
   input  logic [NUM_WAYS-1:0]       we_i,
   input  logic [31:0]               wdat_i,
   input  logic [NUM_WAYS-1:0]       sel_i,
   output logic [31:0]               rdat_o
);

   localparam int DEPTH = 2 ** (SET_W + BLOCK_W - 2);

   logic [31:0] way_rdat [NUM_WAYS];

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      logic [31:0] mem [DEPTH];

      always_ff @(posedge clk) begin
         if (we_i[w]) begin
            mem[wadr_i] <= wdat_i;
         end
         way_rdat[w] <= mem[radr_i];
      end
   end

   // sel_i is one-hot on a hit
   always_comb begin
      rdat_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         rdat_o = rdat_o | (way_rdat[w] & {32{sel_i[w]}});
      end
   end

endmodule

/* icache/icache_tag_store.sv */
// Instruction cache tag store
// One entry per set with valid and tag for every way and the LRU
// history on top, plus the per-way hit compare

`timescale 1ns/1ns

module icache_tag_store #(
   parameter int ADDR_W   = icache_pkg::ADDR_W,
   parameter int BLOCK_W  = icache_pkg::BLOCK_W,
   parameter int SET_W    = icache_pkg::SET_W,
   parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
   input  logic                               clk,
   icache_tag_if.store                        tag_if,
   input  logic [ADDR_W-SET_W-BLOCK_W-1:0]    cmp_tag_i,
   output logic [NUM_WAYS-1:0]                way_hit_o,
   output logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0] lru_hist_o
);

   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W;
   localparam int LRU_W   = NUM_WAYS * (NUM_WAYS - 1) / 2;
   localparam int WAY_E_W = TAG_W + 1;
   localparam int ENTRY_W = NUM_WAYS * WAY_E_W + LRU_W;

   //   entry layout
   //   | lru | way N-1 valid, tag | ... | way 0 valid, tag |
   logic [ENTRY_W-1:0] tag_mem [2**SET_W];

   // Read returns the old entry when the same set is written
   always_ff @(posedge clk) begin
      if (tag_if.we) begin
         tag_mem[tag_if.wr_idx] <= tag_if.wr_entry;
      end
      tag_if.rd_entry <= tag_mem[tag_if.rd_idx];
   end

   assign lru_hist_o = tag_if.rd_entry[ENTRY_W-1 -: LRU_W];

   // A way hits when valid and its tag matches
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
      logic             way_valid;
      logic [TAG_W-1:0] way_tag;

      assign way_valid    = tag_if.rd_entry[w*WAY_E_W + TAG_W];
      assign way_tag      = tag_if.rd_entry[w*WAY_E_W +: TAG_W];
      assign way_hit_o[w] = way_valid && (way_tag == cmp_tag_i);
   end

endmodule

/* icache/icache_ctrl.sv */
// Instruction cache controller
// Sequences lookup, line refill and set invalidation, and sweeps
// the tag RAM clear after reset

`timescale 1ns/1ns

module icache_ctrl #(
   parameter int ADDR_W   = icache_pkg::ADDR_W,
   parameter int BLOCK_W  = icache_pkg::BLOCK_W,
   parameter int SET_W    = icache_pkg::SET_W,
   parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cpu_req_i,
   input  logic [ADDR_W-1:0]                     cpu_adr_i,
   output logic                                  cpu_ack_o,
   output logic                                  refill_req_o,
   output logic [ADDR_W-1:0]                     refill_adr_o,
   input  logic                                  refill_valid_i,
   input  logic                                  inval_req_i,
   input  logic [SET_W-1:0]                      inval_set_i,
   output logic                                  inval_ack_o,
   icache_tag_if.ctrl                            tag_if,
   input  logic [NUM_WAYS-1:0]                   way_hit_i,
   input  logic [NUM_WAYS-1:0]                   victim_i,
   input  logic [NUM_WAYS*(NUM_WAYS-1)/2-1:0]    lru_next_i,
   output logic [NUM_WAYS-1:0]                   lru_access_o,
   output logic [NUM_WAYS-1:0]                   data_we_o,
   output logic [SET_W+BLOCK_W-3:0]              data_radr_o,
   output logic [SET_W+BLOCK_W-3:0]              data_wadr_o
);

   import icache_pkg::*;

   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W;
   localparam int LRU_W   = NUM_WAYS * (NUM_WAYS - 1) / 2;
   localparam int WAY_E_W = TAG_W + 1;
   localparam int ENTRY_W = NUM_WAYS * WAY_E_W + LRU_W;
   localparam int CNT_W   = BLOCK_W - 2;

   ic_state_e           state;
   logic [SET_W-1:0]    set_idx;
   logic [TAG_W-1:0]    adr_tag;
   logic                hit;
   logic                ack_r;
   logic                sweep_busy;
   logic [SET_W-1:0]    sweep_cnt;
   logic [CNT_W-1:0]    word_cnt;
   logic                last_word;
   logic [NUM_WAYS-1:0] victim_r;
   logic [ENTRY_W-1:0]  saved_entry;

   // CPU holds its address until ack, so the index is taken from it directly
   assign set_idx   = cpu_adr_i[BLOCK_W +: SET_W];
   assign adr_tag   = cpu_adr_i[ADDR_W-1 -: TAG_W];
   assign hit       = |way_hit_i;
   assign last_word = &word_cnt;

   assign cpu_ack_o    = ack_r;
   assign refill_req_o = (state == IC_REFILL);
   assign refill_adr_o = {cpu_adr_i[ADDR_W-1:BLOCK_W], {BLOCK_W{1'b0}}};
   assign inval_ack_o  = (state == IC_INVAL) && !sweep_busy;

   // Word RAM read follows the CPU, refill writes count through the line
   assign data_radr_o = cpu_adr_i[SET_W+BLOCK_W-1:2];
   assign data_wadr_o = {set_idx, word_cnt};
   assign data_we_o   = (state == IC_REFILL && refill_valid_i) ? victim_r : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         // Start in the tag clear sweep
         state      <= IC_INVAL;
         sweep_busy <= 1'b1;
         sweep_cnt  <= '0;
         word_cnt   <= '0;
         ack_r      <= 1'b0;
      end else begin
         ack_r <= 1'b0;
         case (state)
            IC_IDLE: begin
               // The request acked last cycle is still on the bus
               if (inval_req_i) begin
                  state <= IC_INVAL;
               end else if (cpu_req_i && !ack_r) begin
                  state <= IC_LOOKUP;
               end
            end
            IC_LOOKUP: begin
               if (hit) begin
                  ack_r <= 1'b1;
                  state <= IC_IDLE;
               end else begin
                  word_cnt <= '0;
                  state    <= IC_REFILL;
               end
            end
            IC_REFILL: begin
               if (refill_valid_i) begin
                  word_cnt <= word_cnt + 1'b1;
                  // Back through idle so the new tag is read again
                  if (last_word) begin
                     state <= IC_IDLE;
                  end
               end
            end
            IC_INVAL: begin
               if (sweep_busy) begin
                  sweep_cnt <= sweep_cnt + 1'b1;
                  if (&sweep_cnt) begin
                     sweep_busy <= 1'b0;
                     state      <= IC_IDLE;
                  end
               end else begin
                  state <= IC_IDLE;
               end
            end
            default: state <= IC_IDLE;
         endcase
      end
   end

   // Victim and the set's entry as seen at the miss
   always_ff @(posedge clk) begin
      if (state == IC_LOOKUP && !hit) begin
         victim_r    <= victim_i;
         saved_entry <= tag_if.rd_entry;
      end
   end

   always_comb begin
      tag_if.rd_idx   = set_idx;
      tag_if.wr_idx   = set_idx;
      tag_if.we       = 1'b0;
      tag_if.wr_entry = tag_if.rd_entry;
      lru_access_o    = '0;
      case (state)
         IC_LOOKUP: begin
            // Hit only updates the LRU history
            if (hit) begin
               lru_access_o = way_hit_i;
               tag_if.wr_entry[ENTRY_W-1 -: LRU_W] = lru_next_i;
               tag_if.we = 1'b1;
            end
         end
         IC_REFILL: begin
            lru_access_o    = victim_r;
            tag_if.wr_entry = saved_entry;
            if (refill_valid_i) begin
               for (int w = 0; w < NUM_WAYS; w++) begin
                  if (victim_r[w] && last_word) begin
                     tag_if.wr_entry[w*WAY_E_W +: WAY_E_W] = {1'b1, adr_tag};
                  end else if (victim_r[w]) begin
                     // Victim line is stale once its first word is overwritten
                     tag_if.wr_entry[w*WAY_E_W + TAG_W] = 1'b0;
                  end
               end
               if (last_word) begin
                  tag_if.wr_entry[ENTRY_W-1 -: LRU_W] = lru_next_i;
               end
               tag_if.we = (word_cnt == '0) || last_word;
            end
         end
         IC_INVAL: begin
            // Clear all ways and the history of one set
            tag_if.wr_idx   = sweep_busy ? sweep_cnt : inval_set_i;
            tag_if.wr_entry = '0;
            tag_if.we       = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

/* icache/icache_top.sv */
// Two-way set-associative instruction cache, top level
// CPU read port, line refill port towards memory and an APB block
// for set invalidation

`timescale 1ns/1ns

module icache_top #(
   parameter int ADDR_W   = icache_pkg::ADDR_W,
   parameter int BLOCK_W  = icache_pkg::BLOCK_W,
   parameter int SET_W    = icache_pkg::SET_W,
   parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
   input  logic              clk,
   input  logic              rst,
   // CPU port
   input  logic              cpu_req_i,
   input  logic [ADDR_W-1:0] cpu_adr_i,
   output logic              cpu_ack_o,
   output logic [31:0]       cpu_dat_o,
   // Refill port
   output logic              refill_req_o,
   output logic [ADDR_W-1:0] refill_adr_o,
   input  logic              refill_valid_i,
   input  logic [31:0]       refill_dat_i,
   // APB slave
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [2:0]        paddr_i,
   input  logic [31:0]       pwdata_i,
   output logic [31:0]       prdata_o,
   output logic              pready_o,
   output logic              pslverr_o
);

   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W;
   localparam int LRU_W   = NUM_WAYS * (NUM_WAYS - 1) / 2;
   localparam int ENTRY_W = NUM_WAYS * (TAG_W + 1) + LRU_W;
   localparam int WADR_W  = SET_W + BLOCK_W - 2;

   logic [NUM_WAYS-1:0] way_hit;
   logic [NUM_WAYS-1:0] victim;
   logic [NUM_WAYS-1:0] lru_access;
   logic [LRU_W-1:0]    lru_hist;
   logic [LRU_W-1:0]    lru_next;
   logic [NUM_WAYS-1:0] data_we;
   logic [WADR_W-1:0]   data_radr;
   logic [WADR_W-1:0]   data_wadr;
   logic                inval_req;
   logic [SET_W-1:0]    inval_set;
   logic                inval_ack;

   icache_tag_if #(.SET_W(SET_W), .ENTRY_W(ENTRY_W)) tag_if ();

   icache_cfg_apb #(.SET_W(SET_W)) u_cfg (
      .clk, .rst,
      .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o,
      .inval_req_o(inval_req), .inval_set_o(inval_set), .inval_ack_i(inval_ack)
   );

   icache_ctrl #(
      .ADDR_W(ADDR_W), .BLOCK_W(BLOCK_W), .SET_W(SET_W), .NUM_WAYS(NUM_WAYS)
   ) u_ctrl (
      .clk, .rst,
      .cpu_req_i, .cpu_adr_i, .cpu_ack_o,
      .refill_req_o, .refill_adr_o, .refill_valid_i,
      .inval_req_i(inval_req), .inval_set_i(inval_set), .inval_ack_o(inval_ack),
      .tag_if(tag_if.ctrl),
      .way_hit_i(way_hit), .victim_i(victim), .lru_next_i(lru_next),
      .lru_access_o(lru_access), .data_we_o(data_we),
      .data_radr_o(data_radr), .data_wadr_o(data_wadr)
   );

   // Address tag compared against both ways
   icache_tag_store #(
      .ADDR_W(ADDR_W), .BLOCK_W(BLOCK_W), .SET_W(SET_W), .NUM_WAYS(NUM_WAYS)
   ) u_tags (
      .clk, .tag_if(tag_if.store),
      .cmp_tag_i(cpu_adr_i[ADDR_W-1 -: TAG_W]),
      .way_hit_o(way_hit), .lru_hist_o(lru_hist)
   );

   icache_data_ways #(.BLOCK_W(BLOCK_W), .SET_W(SET_W), .NUM_WAYS(NUM_WAYS)) u_data (
      .clk, .radr_i(data_radr), .wadr_i(data_wadr), .we_i(data_we),
      .wdat_i(refill_dat_i), .sel_i(way_hit), .rdat_o(cpu_dat_o)
   );

   icache_lru #(.NUM_WAYS(NUM_WAYS)) u_lru (
      .hist_i(lru_hist), .access_i(lru_access), .hist_o(lru_next), .victim_o(victim)
   );

endmodule

/* bench/tb_clk_gen.sv */
// Testbench clock and reset
// Free running clock, reset held high for a number of rising edges

`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

   // Released just after an edge, like the other inputs
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2;
      rst_o = 1'b0;
   end

endmodule

/* bench/tb_icache.sv */
// Instruction cache testbench
// Drives CPU reads, serves refills from a scrambled memory model and
// issues APB accesses, checking data and hit or miss against a cache model

`timescale 1ns/1ns

module tb_icache;

   import icache_pkg::*;

   localparam int TAG_W      = ADDR_W - SET_W - BLOCK_W;
   localparam int NUM_SETS   = 2 ** SET_W;
   localparam int LINE_WDS   = 2 ** (BLOCK_W - 2);
   localparam int READ_TMO   = 400;
   localparam int APB_TMO    = 50;
   localparam int REFILL_TMO = 200;
   // Directed lines, set 35 and three tags in set 5
   localparam logic [ADDR_W-1:0] LINE_ADR = 'h0000_1234;
   localparam logic [ADDR_W-1:0] ADR_A    = 'h0002_0050;
   localparam logic [ADDR_W-1:0] ADR_B    = 'h0003_0054;
   localparam logic [ADDR_W-1:0] ADR_C    = 'h0004_0058;
   // Random window base, sets and tag bits above it start at zero
   localparam logic [ADDR_W-1:0] WIN_BASE = 'h0040_0000;

   logic              clk;
   logic              rst;
   logic              cpu_req;
   logic [ADDR_W-1:0] cpu_adr;
   logic              cpu_ack;
   logic [31:0]       cpu_dat;
   logic              refill_req;
   logic [ADDR_W-1:0] refill_adr;
   logic              refill_valid;
   logic [31:0]       refill_dat;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [2:0]        paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;

   // Cache model, per set the valid bit, tag and last use of each way
   bit               m_valid [NUM_SETS][NUM_WAYS];
   logic [TAG_W-1:0] m_tag   [NUM_SETS][NUM_WAYS];
   int               m_stamp [NUM_SETS][NUM_WAYS];
   int               use_cnt;

   tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(8)) u_clk (.clk_o(clk), .rst_o(rst));

   icache_top #(
      .ADDR_W(ADDR_W), .BLOCK_W(BLOCK_W), .SET_W(SET_W), .NUM_WAYS(NUM_WAYS)
   ) u_dut (
      .clk, .rst,
      .cpu_req_i(cpu_req), .cpu_adr_i(cpu_adr), .cpu_ack_o(cpu_ack), .cpu_dat_o(cpu_dat),
      .refill_req_o(refill_req), .refill_adr_o(refill_adr),
      .refill_valid_i(refill_valid), .refill_dat_i(refill_dat),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
      .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
   );

   task automatic abort_run(input string why);
      $display("%0t %s", $time, why);
      $display("TB FAILED");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // Memory content, a scramble of the word address
   function automatic logic [31:0] mem_word(input logic [ADDR_W-1:0] addr);
      logic [31:0] w;
      w = 32'(addr >> 2);
      return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a3c_0ff1;
   endfunction

   task automatic model_inval(input int set);
      for (int w = 0; w < NUM_WAYS; w++) begin
         m_valid[set][w] = 1'b0;
         // Cleared history leaves way 0 the oldest
         m_stamp[set][w] = w;
      end
   endtask

   function automatic int find_way(input int set, input logic [TAG_W-1:0] tag);
      int way;
      way = -1;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (m_valid[set][w] && m_tag[set][w] == tag) begin
            way = w;
         end
      end
      return way;
   endfunction

   // Least recently used way, older than every other way
   function automatic int victim_way(input int set);
      int v;
      v = 0;
      for (int w = 1; w < NUM_WAYS; w++) begin
         if (m_stamp[set][w] < m_stamp[set][v]) begin
            v = w;
         end
      end
      return v;
   endfunction

   task automatic touch_way(input int set, input int way);
      use_cnt++;
      m_stamp[set][way] = use_cnt;
   endtask

   // One CPU read, counting cycles from the first drive of the request
   task automatic cpu_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                           output int rises, output int ack_n, output int ref_n);
      logic [ADDR_W-1:0] line;
      logic              prev;
      bit                done;
      line = addr;
      line[BLOCK_W-1:0] = '0;
      prev  = 1'b0;
      done  = 1'b0;
      rises = 0;
      ack_n = 0;
      ref_n = -1;
      @(posedge clk);
      #2;
      cpu_req = 1'b1;
      cpu_adr = addr;
      while (!done) begin
         @(negedge clk);
         if (refill_req && !prev) begin
            if (rises == 0) ref_n = ack_n;
            rises++;
            check_val("refill_adr_o", 32'(refill_adr), 32'(line));
         end
         prev = refill_req;
         if (cpu_ack) begin
            data = cpu_dat;
            done = 1'b1;
         end else if (ack_n == READ_TMO) begin
            abort_run("timeout waiting for cpu_ack_o");
         end else begin
            ack_n++;
         end
      end
      @(posedge clk);
      #2;
      cpu_req = 1'b0;
   endtask

   // Read checked against the memory and cache models, model updated after
   task automatic do_read(input logic [ADDR_W-1:0] addr, input bit timed, output bit hit);
      int               set;
      int               way;
      logic [TAG_W-1:0] tag;
      logic [31:0]      data;
      int               rises;
      int               ack_n;
      int               ref_n;
      set = int'(addr[BLOCK_W +: SET_W]);
      tag = addr[ADDR_W-1 -: TAG_W];
      way = find_way(set, tag);
      cpu_read(addr, data, rises, ack_n, ref_n);
      hit = (rises == 0);
      check_val("cpu_dat_o", data, mem_word(addr));
      check_val("cache hit", 32'(hit), 32'(way >= 0));
      if (!timed) begin
         // First read waits out the tag clear sweep
         check_val("cpu_ack_o after sweep", 32'(ack_n >= NUM_SETS), 32'd1);
      end else if (hit) begin
         check_val("cpu_ack_o latency", 32'(ack_n), 32'd2);
      end else begin
         check_val("refill_req_o latency", 32'(ref_n), 32'd2);
      end
      if (!hit) begin
         check_val("refill_req_o count", 32'(rises), 32'd1);
         way = victim_way(set);
         m_valid[set][way] = 1'b1;
         m_tag[set][way]   = tag;
      end
      touch_way(set, way);
   endtask

   task automatic read_expect(input logic [ADDR_W-1:0] addr, input bit exp_hit);
      bit hit;
      do_read(addr, 1'b1, hit);
      check_val("expected hit", 32'(hit), 32'(exp_hit));
   endtask

   // APB transfer with setup and access phase, waits counts stalled cycles
   task automatic apb_xfer(input bit write, input logic [2:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output bit err, output int waits);
      @(posedge clk);
      #2;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #2;
      penable = 1'b1;
      waits   = 0;
      @(negedge clk);
      while (!pready) begin
         if (waits == APB_TMO) begin
            abort_run("timeout waiting for pready_o");
         end
         waits++;
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic invalidate_set(input int set);
      logic [31:0] rdata;
      bit          err;
      int          waits;
      apb_xfer(1'b1, CFG_INVAL, 32'(set), rdata, err, waits);
      check_val("pslverr_o", 32'(err), 32'd0);
      // Latched, taken in idle, then one cycle of IC_INVAL
      check_val("pready_o wait", 32'(waits), 32'd3);
      model_inval(set);
   endtask

   // Memory side, serves each refill request with random gaps
   initial begin : refill_responder
      int idx;
      int busy;
      idx          = 0;
      busy         = 0;
      refill_valid = 1'b0;
      refill_dat   = '0;
      forever begin
         @(posedge clk);
         #2;
         refill_valid = 1'b0;
         if (!refill_req) begin
            idx  = 0;
            busy = 0;
         end else if (busy == REFILL_TMO) begin
            abort_run("refill_req_o held without completing the line");
         end else begin
            busy++;
            if (idx < LINE_WDS && $urandom_range(2, 0) != 0) begin
               refill_valid = 1'b1;
               refill_dat   = mem_word(refill_adr + ADDR_W'(idx * 4));
               idx++;
            end
         end
      end
   end

   initial begin : stimulus
      logic [ADDR_W-1:0] addr;
      logic [31:0]       rdata;
      bit                hit;
      bit                err;
      int                waits;
      int                n;
      void'($urandom(32'h3b21_4e04));
      cpu_req = 1'b0;
      cpu_adr = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      use_cnt = NUM_WAYS;
      for (int s = 0; s < NUM_SETS; s++) begin
         model_inval(s);
      end
      n = 0;
      @(posedge clk);
      while (rst) begin
         if (n == 20) begin
            abort_run("reset never released");
         end
         n++;
         @(posedge clk);
      end

      // Cold miss right after reset, then a hit in the same line
      do_read(LINE_ADR, 1'b0, hit);
      check_val("expected hit", 32'(hit), 32'd0);
      read_expect(LINE_ADR + 'h8, 1'b1);

      // C replaces B, the older of the two
      read_expect(ADR_A, 1'b0);
      read_expect(ADR_B, 1'b0);
      read_expect(ADR_A, 1'b1);
      read_expect(ADR_C, 1'b0);
      read_expect(ADR_A, 1'b1);
      read_expect(ADR_B, 1'b0);

      // Set invalidation and read back of the index
      invalidate_set(int'(LINE_ADR[BLOCK_W +: SET_W]));
      apb_xfer(1'b0, CFG_LAST, '0, rdata, err, waits);
      check_val("prdata_o", rdata, 32'(LINE_ADR[BLOCK_W +: SET_W]));
      check_val("pslverr_o", 32'(err), 32'd0);
      check_val("pready_o wait", 32'(waits), 32'd0);
      read_expect(LINE_ADR, 1'b0);

      // Unmapped offsets
      apb_xfer(1'b1, 3'd2, 32'h0000_0011, rdata, err, waits);
      check_val("pslverr_o", 32'(err), 32'd1);
      apb_xfer(1'b0, 3'd6, '0, rdata, err, waits);
      check_val("pslverr_o", 32'(err), 32'd1);

      // Three tags over four sets with occasional invalidations
      for (int i = 0; i < 400; i++) begin
         if ($urandom_range(11, 0) == 0) begin
            invalidate_set(int'($urandom_range(3, 0)));
         end
         addr = WIN_BASE;
         addr[BLOCK_W+SET_W +: 2] = 2'($urandom_range(2, 0));
         addr[BLOCK_W +: 2] = 2'($urandom_range(3, 0));
         addr[2 +: BLOCK_W-2] = (BLOCK_W-2)'($urandom_range(LINE_WDS - 1, 0));
         do_read(addr, 1'b1, hit);
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

/* icache_top.f */
common/icache_pkg.sv
common/icache_tag_if.sv
rtl/icache_cfg_apb.sv
icache/icache_lru.sv
icache/icache_data_ways.sv
icache/icache_tag_store.sv
icache/icache_ctrl.sv
icache/icache_top.sv
bench/tb_clk_gen.sv
bench/tb_icache.sv

/* run.sh */
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_icache \
   -f icache_top.f --Mdir obj_dir -o tb_icache
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_icache
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

exit 0
